/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run tb_gat_attn, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_gat_attn -Mdir obj_dir -o sim_tb -f sim.f
	./obj_dir/sim_tb | tee sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/attn_dot_unit.sv */
`timescale 1ns/1ps

module attn_dot_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  gat_pkg::a_half_t a_half_i,
  input  logic             node_vld_i,
  input  gat_pkg::node_t   node_i,
  output gat_pkg::score_t  score_o
);

  import gat_pkg::*;

  // adder tree in heap order
  // leaves NUM_FEATURE_OUT..2N-1 hold the products
  // node 1 is the root
  // a node at depth d is registered NUM_STAGES-d cycles after input
  logic signed [DMVM_DATA_WIDTH-1:0] sum_q [1:2*NUM_FEATURE_OUT-1];

  // flags follow the data through every stage
  logic [NUM_STAGES-1:0] vld_q;
  logic [NUM_STAGES-1:0] first_q;

  always_ff @(posedge clk) begin
    // stage 1 forms signed 12x8 products sign-extended into the score width
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      sum_q[NUM_FEATURE_OUT + j] <= $signed(node_i.feat[j]) * $signed(a_half_i[j]);
    end
    // stages 2 to 5 do one tree level each
    for (int k = 1; k < NUM_FEATURE_OUT; k++) begin
      sum_q[k] <= sum_q[2*k] + sum_q[2*k + 1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q   <= '0;
      first_q <= '0;
    end else begin
      vld_q   <= {vld_q[NUM_STAGES-2:0], node_vld_i};
      first_q <= {first_q[NUM_STAGES-2:0], node_i.first & node_vld_i};
    end
  end

  assign score_o.vld   = vld_q[NUM_STAGES-1];
  assign score_o.first = first_q[NUM_STAGES-1];
  assign score_o.score = sum_q[1];

  // fixed latency with no bubbles and no lost nodes
  dot_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    score_o.vld == $past(node_vld_i, NUM_STAGES));

endmodule

/* design/attn_vec_store.sv */
`timescale 1ns/1ps

module attn_vec_store (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                a_wr_i,
  input  logic [gat_pkg::A_INDEX_WIDTH-1:0]   a_addr_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0] a_data_i,
  output gat_pkg::a_half_t                    a_src_o,
  output gat_pkg::a_half_t                    a_nbr_o,
  output logic                                a_rdy_o
);

  import gat_pkg::*;

  logic [DATA_WIDTH-1:0] a_q [A_DEPTH];
  logic [A_DEPTH-1:0]    written_q;
  logic [A_DEPTH-1:0]    written_nxt;
  logic                  rdy_q;

  // entry storage
  always_ff @(posedge clk) begin
    if (a_wr_i) begin
      a_q[a_addr_i] <= a_data_i;
    end
  end

  always_comb begin
    written_nxt = written_q;
    if (a_wr_i) begin
      written_nxt[a_addr_i] = 1'b1;
    end
  end

  // ready comes up together with the last new index
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      written_q <= '0;
      rdy_q     <= 1'b0;
    end else begin
      written_q <= written_nxt;
      rdy_q     <= &written_nxt;
    end
  end

  // split into target half and neighbour half
  always_comb begin
    for (int i = 0; i < HALF_A_SIZE; i++) begin
      a_src_o[i] = a_q[i];
      a_nbr_o[i] = a_q[HALF_A_SIZE + i];
    end
  end

  assign a_rdy_o = rdy_q;

  a_addr_in_range: assert property (
    @(posedge clk) disable iff (!rst_n) a_wr_i |-> (int'(a_addr_i) < A_DEPTH));

endmodule

/* design/coef_combiner.sv */
`timescale 1ns/1ps

module coef_combiner (
  input  logic            clk,
  input  logic            rst_n,
  input  gat_pkg::score_t src_score_i,
  input  gat_pkg::score_t nbr_score_i,
  output logic            coef_vld_o,
  output gat_pkg::coef_t  coef_o
);

  import gat_pkg::*;

  logic                              open_sub;
  logic signed [DMVM_DATA_WIDTH-1:0] held_q;
  logic signed [DMVM_DATA_WIDTH-1:0] src_sel;
  logic [NUM_NODE_WIDTH-1:0]         idx_q;
  logic [NUM_NODE_WIDTH-1:0]         idx_sel;

  // one bit wider than a score so the sum cannot wrap
  logic signed [DMVM_DATA_WIDTH:0]   e_sum;
  logic signed [DMVM_DATA_WIDTH:0]   e_lrelu;
  logic signed [DMVM_DATA_WIDTH:0]   e_scaled;
  logic signed [DATA_WIDTH-1:0]      e_sat;

  assign open_sub = src_score_i.vld & src_score_i.first;

  // the target node uses its own score and later nodes the held one
  assign src_sel = open_sub ? src_score_i.score : held_q;
  assign idx_sel = open_sub ? '0 : idx_q;

  always_comb begin
    e_sum    = $signed({src_sel[DMVM_DATA_WIDTH-1], src_sel})
             + $signed({nbr_score_i.score[DMVM_DATA_WIDTH-1], nbr_score_i.score});
    e_lrelu  = e_sum[DMVM_DATA_WIDTH] ? (e_sum >>> LRELU_SHIFT) : e_sum;
    e_scaled = e_lrelu >>> COEF_SHIFT;
    // in range when all bits above the result width match its sign
    if (&e_scaled[DMVM_DATA_WIDTH:DATA_WIDTH-1] || ~|e_scaled[DMVM_DATA_WIDTH:DATA_WIDTH-1]) begin
      e_sat = e_scaled[DATA_WIDTH-1:0];
    end else if (e_scaled[DMVM_DATA_WIDTH]) begin
      e_sat = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    end else begin
      e_sat = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    end
  end

  // held target score
  always_ff @(posedge clk) begin
    if (open_sub) begin
      held_q <= src_score_i.score;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx_q      <= '0;
      coef_vld_o <= 1'b0;
    end else begin
      coef_vld_o <= nbr_score_i.vld;
      if (nbr_score_i.vld) begin
        idx_q <= idx_sel + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    coef_o.value    <= e_sat;
    coef_o.node_idx <= idx_sel;
  end

  // both dot units see the same node stream
  score_in_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    (src_score_i.vld == nbr_score_i.vld)
    && (!src_score_i.vld || src_score_i.first == nbr_score_i.first));

  node_idx_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    coef_vld_o |-> (int'(coef_o.node_idx) < MAX_NODES));

endmodule

/* design/gat_attn_top.sv */
`timescale 1ns/1ps

module gat_attn_top (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // attention vector load
  input  logic                                  a_wr_i,
  input  logic [gat_pkg::A_INDEX_WIDTH-1:0]     a_addr_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0] a_data_i,
  output logic                                  a_rdy_o,

  // node stream
  input  logic                                  node_vld_i,
  input  gat_pkg::node_t                        node_i,

  // coefficient stream
  output logic                                  coef_vld_o,
  output gat_pkg::coef_t                        coef_o
);

  import gat_pkg::*;

  a_half_t a_src;
  a_half_t a_nbr;
  score_t  src_score;
  score_t  nbr_score;

  attn_vec_store u_attn_vec_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .a_wr_i   (a_wr_i),
    .a_addr_i (a_addr_i),
    .a_data_i (a_data_i),
    .a_src_o  (a_src),
    .a_nbr_o  (a_nbr),
    .a_rdy_o  (a_rdy_o)
  );

  // target half
  attn_dot_unit u_src_dot (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_half_i   (a_src),
    .node_vld_i (node_vld_i),
    .node_i     (node_i),
    .score_o    (src_score)
  );

  // neighbour half
  attn_dot_unit u_nbr_dot (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_half_i   (a_nbr),
    .node_vld_i (node_vld_i),
    .node_i     (node_i),
    .score_o    (nbr_score)
  );

  coef_combiner u_coef_combiner (
    .clk         (clk),
    .rst_n       (rst_n),
    .src_score_i (src_score),
    .nbr_score_i (nbr_score),
    .coef_vld_o  (coef_vld_o),
    .coef_o      (coef_o)
  );

  // nodes only after a is loaded since there is no back-pressure
  node_after_rdy: assert property (
    @(posedge clk) disable iff (!rst_n) node_vld_i |-> a_rdy_o);

  // dot pipeline plus the combiner register keep node order
  coef_in_order: assert property (
    @(posedge clk) disable iff (!rst_n)
    coef_vld_o == $past(node_vld_i, NUM_STAGES + 1));

endmodule

/* design/gat_pkg.sv */
package gat_pkg;

  // entry and coefficient width
  localparam int DATA_WIDTH      = 8;
  // one Wh feature, signed
  localparam int WH_DATA_WIDTH   = 12;
  localparam int NUM_FEATURE_OUT = 16;

  // attention vector a holds the target half then the neighbour half
  localparam int A_DEPTH         = NUM_FEATURE_OUT * 2;
  localparam int HALF_A_SIZE     = A_DEPTH / 2;
  localparam int A_INDEX_WIDTH   = $clog2(A_DEPTH);

  // subgraph limits
  localparam int MAX_NODES       = 168;
  localparam int NUM_NODE_WIDTH  = $clog2(MAX_NODES);

  // dot-product score wide enough for 16 products of 12x8 bits
  localparam int DMVM_DATA_WIDTH = 24;
  // one multiply stage plus log2(16) adder levels
  localparam int NUM_STAGES      = $clog2(NUM_FEATURE_OUT) + 1;

  // leaky relu slope is 1/8
  localparam int LRELU_SHIFT     = 3;
  localparam int COEF_SHIFT      = 8;

  typedef logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] wh_vec_t;

  typedef logic [HALF_A_SIZE-1:0][DATA_WIDTH-1:0] a_half_t;

  // first marks the target node that opens a subgraph
  typedef struct packed {
    wh_vec_t feat;
    logic    first;
  } node_t;

  typedef struct packed {
    logic                              vld;
    logic                              first;
    logic signed [DMVM_DATA_WIDTH-1:0] score;
  } score_t;

  typedef struct packed {
    logic signed [DATA_WIDTH-1:0] value;
    logic [NUM_NODE_WIDTH-1:0]    node_idx;
  } coef_t;

endpackage

/* sim.f */
+incdir+tb
design/gat_pkg.sv
design/attn_vec_store.sv
design/attn_dot_unit.sv
design/coef_combiner.sv
design/gat_attn_top.sv
tb/tb_gat_attn.sv

/* tb/gat_attn_tests.svh */
`ifndef GAT_ATTN_TESTS_SVH
`define GAT_ATTN_TESTS_SVH

// each row holds name, first, random, base, step and idle cycles before the row
// fixed rows use base + step*j for feature j
// random rows draw every feature from -base..base
localparam int NUM_ROWS = 24;

task automatic fill_table();
  // positive sums scaled and saturated high
  add_row("pos_target",    1'b1, 1'b0,    10,    0, 2);
  add_row("pos_ramp",      1'b0, 1'b0,     4,    2, 0);
  add_row("pos_saturate",  1'b1, 1'b0,  1000,    0, 1);
  add_row("pos_sat_ramp",  1'b0, 1'b0,   200,  100, 0);
  // negative sums through the leaky relu slope
  add_row("neg_leaky",     1'b1, 1'b0,   -20,    0, 2);
  add_row("neg_ramp",      1'b0, 1'b0,    -5,   -3, 0);
  add_row("neg_saturate",  1'b1, 1'b0, -2000,    0, 1);
  add_row("neg_mixed",     1'b0, 1'b0,  -600,   80, 0);
  // held target score and index count within one subgraph
  add_row("sub_target",    1'b1, 1'b0,    50,    0, 3);
  add_row("sub_nbr_1",     1'b0, 1'b0,   -30,    0, 0);
  add_row("sub_nbr_2",     1'b0, 1'b0,     5,    0, 1);
  add_row("sub_nbr_3",     1'b0, 1'b0,     0,    7, 0);
  add_row("sub_nbr_4",     1'b0, 1'b0,  -100,   13, 2);
  add_row("new_target",    1'b1, 1'b0,    -8,    1, 0);
  add_row("new_nbr_1",     1'b0, 1'b0,    60,   -8, 0);
  // back to back with no idle cycles
  add_row("b2b_target",    1'b1, 1'b1,    40,    0, 0);
  add_row("b2b_nbr_1",     1'b0, 1'b1,    40,    0, 0);
  add_row("b2b_nbr_2",     1'b0, 1'b1,   200,    0, 0);
  add_row("b2b_nbr_3",     1'b0, 1'b0,     3,    9, 0);
  add_row("b2b_nbr_4",     1'b0, 1'b1,    40,    0, 0);
  // random features
  add_row("rand_target",   1'b1, 1'b1,   300,    0, 2);
  add_row("rand_nbr_1",    1'b0, 1'b1,   300,    0, 1);
  add_row("rand_nbr_2",    1'b0, 1'b1,  2047,    0, 0);
  add_row("rand_nbr_3",    1'b0, 1'b1,   100,    0, 3);
endtask

`endif

/* tb/tb_gat_attn.sv */
`timescale 1ns/1ps

module tb_gat_attn;

  import gat_pkg::*;

  localparam int SEED        = 26907;
  localparam int EXP_LATENCY = 6;

  typedef struct packed {
    bit first;
    bit rnd;
    int base;
    int step;
    int gap;
  } row_t;

  logic                         clk;
  logic                         rst_n;
  logic                         a_wr_i;
  logic [A_INDEX_WIDTH-1:0]     a_addr_i;
  logic signed [DATA_WIDTH-1:0] a_data_i;
  logic                         a_rdy_o;
  logic                         node_vld_i;
  node_t                        node_i;
  logic                         coef_vld_o;
  coef_t                        coef_o;

  row_t    rows[$];
  string   names[$];
  wh_vec_t feats[$];
  coef_t   exp_coef[$];
  // last value written to each entry of a
  int      a_ref[A_DEPTH];

  // nodes in flight with the oldest first
  coef_t exp_q[$];
  int    row_q[$];
  int    sent_q[$];

  int cycle_cnt = 0;
  int err_cnt   = 0;
  int test_cnt  = 0;
  int fail_cnt  = 0;

  gat_attn_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_wr_i     (a_wr_i),
    .a_addr_i   (a_addr_i),
    .a_data_i   (a_data_i),
    .a_rdy_o    (a_rdy_o),
    .node_vld_i (node_vld_i),
    .node_i     (node_i),
    .coef_vld_o (coef_vld_o),
    .coef_o     (coef_o)
  );

  task automatic add_row(input string name, input bit first, input bit rnd,
                         input int base, input int step, input int gap);
    row_t row;
    row.first = first;
    row.rnd   = rnd;
    row.base  = base;
    row.step  = step;
    row.gap   = gap;
    rows.push_back(row);
    names.push_back(name);
  endtask

  `include "gat_attn_tests.svh"

  localparam int TIMEOUT_CYCLES = NUM_ROWS * 8 + 200;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
  end

  task automatic report_test(input string name, input bit ok);
    test_cnt++;
    if (!ok) begin
      fail_cnt++;
    end
    $display("test %s: %s", name, ok ? "ok" : "FAILED");
  endtask

  task automatic check_rdy(input logic got, input logic exp, output bit ok);
    ok = (got === exp);
    if (!ok) begin
      $display("error at %0t: a_rdy_o expected %b got %b", $time, exp, got);
      err_cnt++;
    end
  endtask

  task automatic check_coef(input coef_t got, input coef_t exp, output bit ok);
    ok = (got === exp);
    if (!ok) begin
      $display("error at %0t: coef_o expected value %0d idx %0d, got value %0d idx %0d",
               $time, exp.value, exp.node_idx, got.value, got.node_idx);
      err_cnt++;
    end
  endtask

  // weights all positive so the sign of a score follows the features
  function automatic int a_value(input int i);
    return 5 + 3 * i;
  endfunction

  task automatic write_a(input int addr, input int val);
    @(posedge clk);
    #1;
    a_wr_i   = 1'b1;
    a_addr_i = addr[A_INDEX_WIDTH-1:0];
    a_data_i = val[DATA_WIDTH-1:0];
    a_ref[addr] = val;
  endtask

  task automatic idle_a();
    @(posedge clk);
    #1;
    a_wr_i = 1'b0;
  endtask

  task automatic load_a();
    bit ok;
    // index 5 first gets a stale value that the sweep below rewrites
    write_a(5, -77);
    for (int i = 0; i < A_DEPTH - 1; i++) begin
      write_a(i, a_value(i));
    end
    idle_a();
    @(negedge clk);
    check_rdy(a_rdy_o, 1'b0, ok);
    report_test("rdy_low_31", ok);
    write_a(A_DEPTH - 1, a_value(A_DEPTH - 1));
    idle_a();
    @(negedge clk);
    check_rdy(a_rdy_o, 1'b1, ok);
    report_test("rdy_high_32", ok);
  endtask

  task automatic build_table();
    wh_vec_t f;
    int      v;
    fill_table();
    if (rows.size() != NUM_ROWS) begin
      $display("table holds %0d rows but %0d were declared", rows.size(), NUM_ROWS);
      err_cnt++;
    end
    foreach (rows[r]) begin
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        if (rows[r].rnd) begin
          v = int'($urandom_range(2 * rows[r].base)) - rows[r].base;
        end else begin
          v = rows[r].base + rows[r].step * j;
        end
        f[j] = v[WH_DATA_WIDTH-1:0];
      end
      feats.push_back(f);
    end
  endtask

  function automatic int dot_half(input wh_vec_t feat, input int base);
    int acc = 0;
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      acc += $signed(feat[j]) * a_ref[base + j];
    end
    return acc;
  endfunction

  // slope 1/8 below zero then /256 then clamp to 8 bits
  function automatic logic signed [DATA_WIDTH-1:0] lrelu_scale_sat(input int e);
    int s;
    s = (e < 0) ? (e >>> LRELU_SHIFT) : e;
    s = s >>> COEF_SHIFT;
    if (s > 127) begin
      s = 127;
    end else if (s < -128) begin
      s = -128;
    end
    return s[DATA_WIDTH-1:0];
  endfunction

  task automatic build_expected();
    int    held;
    int    nbr;
    int    idx;
    coef_t c;
    held = 0;
    idx  = 0;
    foreach (feats[r]) begin
      nbr = dot_half(feats[r], HALF_A_SIZE);
      if (rows[r].first) begin
        held = dot_half(feats[r], 0);
        idx  = 0;
      end
      c.value    = lrelu_scale_sat(held + nbr);
      c.node_idx = idx[NUM_NODE_WIDTH-1:0];
      exp_coef.push_back(c);
      idx++;
    end
  endtask

  task automatic send_nodes();
    for (int r = 0; r < rows.size(); r++) begin
      repeat (rows[r].gap) begin
        @(posedge clk);
        #1;
        node_vld_i = 1'b0;
      end
      @(posedge clk);
      #1;
      node_vld_i   = 1'b1;
      node_i.feat  = feats[r];
      node_i.first = rows[r].first;
      exp_q.push_back(exp_coef[r]);
      row_q.push_back(r);
      sent_q.push_back(cycle_cnt);
    end
    @(posedge clk);
    #1;
    node_vld_i = 1'b0;
  endtask

  // output side sampled mid-cycle
  always @(negedge clk) begin
    coef_t exp_c;
    int    r;
    int    lat;
    bit    ok;
    if (rst_n && coef_vld_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("coef_vld_o pulsed at %0t with no node outstanding", $time);
        err_cnt++;
      end else begin
        exp_c = exp_q.pop_front();
        r     = row_q.pop_front();
        lat   = cycle_cnt - sent_q.pop_front();
        check_coef(coef_o, exp_c, ok);
        if (lat != EXP_LATENCY) begin
          $display("test %s: coefficient came %0d cycles after its node, not %0d",
                   names[r], lat, EXP_LATENCY);
          err_cnt++;
          ok = 1'b0;
        end
        report_test(names[r], ok);
      end
    end
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout after %0d cycles, %0d coefficients never arrived",
             cycle_cnt, exp_q.size());
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    bit ok;
    void'($urandom(SEED));
    rst_n      = 1'b0;
    a_wr_i     = 1'b0;
    a_addr_i   = '0;
    a_data_i   = '0;
    node_vld_i = 1'b0;
    node_i     = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_rdy(a_rdy_o, 1'b0, ok);
    report_test("rdy_after_reset", ok);

    load_a();
    build_table();
    build_expected();
    send_nodes();

    // drain the pipeline and wait a few idle cycles for stray strobes
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
